/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_top -f flist.f -o tb_sim
	out=$$(./obj_dir/tb_sim); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

/* alu_8bit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_8bit import cpu_pkg::*; (
	input wire alu_op_t alu_op,
	input wire logic [DATA_W-1:0] d,
	input wire logic df,
	input wire logic [DATA_W-1:0] b,
	output logic [DATA_W-1:0] d_next,
	output logic df_next
);

	logic [DATA_W:0] sum; // Carry out in the top bit

	always_comb begin
		sum = {1'b0, d};
		d_next = d;
		df_next = df;
		case (alu_op)
			OR: d_next = d | b;
			AND: d_next = d & b;
			XOR: d_next = d ^ b;
			ADD: sum = {1'b0, d} + {1'b0, b};
			ADC: sum = {1'b0, d} + {1'b0, b} + {{DATA_W{1'b0}}, df};
			SD: sum = {1'b0, b} + {1'b0, ~d} + 1'b1; // DF set means no borrow
			SDB: sum = {1'b0, b} + {1'b0, ~d} + {{DATA_W{1'b0}}, df};
			SM: sum = {1'b0, d} + {1'b0, ~b} + 1'b1;
			SMB: sum = {1'b0, d} + {1'b0, ~b} + {{DATA_W{1'b0}}, df};
			SHR: sum = {d[0], 1'b0, d[DATA_W-1:1]};
			SHL: sum = {d, 1'b0};
			RSHR: sum = {d[0], df, d[DATA_W-1:1]};
			RSHL: sum = {d, df};
			default: ;
		endcase
		if (alu_op inside {ADD, ADC, SD, SDB, SM, SMB, SHR, SHL, RSHR, RSHL}) begin
			{df_next, d_next} = sum;
		end
	end

endmodule

`default_nettype wire

/* cdp1802_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cdp1802_top import cpu_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [3:0] ef_n,
	input wire logic [3:0] rom_din,
	output logic [3:0] rom_dout,
	output logic [3:0] rom_oe,
	output logic rom_cs_n,
	output logic rom_sclk,
	output logic q
);

	mem_req_t mem_req;
	logic mem_start;
	logic mem_done;
	logic [DATA_W-1:0] mem_rdata;
	alu_op_t alu_op;
	logic [DATA_W-1:0] alu_d, alu_b, alu_d_next;
	logic alu_df, alu_df_next;

	cpu_sequencer u_seq (
		.clk(clk), .rst_n(rst_n), .ef_n(ef_n),
		.mem_req(mem_req), .mem_start(mem_start),
		.mem_done(mem_done), .mem_rdata(mem_rdata),
		.alu_op(alu_op), .alu_d(alu_d), .alu_df(alu_df), .alu_b(alu_b),
		.alu_d_next(alu_d_next), .alu_df_next(alu_df_next),
		.q(q)
	);

	mem_router u_mem (
		.clk(clk), .rst_n(rst_n),
		.mem_req(mem_req), .mem_start(mem_start),
		.mem_done(mem_done), .mem_rdata(mem_rdata),
		.rom_din(rom_din), .rom_dout(rom_dout), .rom_oe(rom_oe),
		.rom_cs_n(rom_cs_n), .rom_sclk(rom_sclk)
	);

	alu_8bit u_alu (
		.alu_op(alu_op), .d(alu_d), .df(alu_df), .b(alu_b),
		.d_next(alu_d_next), .df_next(alu_df_next)
	);

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;
	localparam int NREGS = 16;
	localparam int REG_AW = $clog2(NREGS);

	// Internal scratch RAM, mirrored over the upper half of the address space
	localparam int RAM_DEPTH = 128;
	localparam int RAM_AW = $clog2(RAM_DEPTH);
	localparam int RAM_BASE_BIT = 15;

	localparam logic [DATA_W-1:0] FLASH_CMD_READ = 8'hEB; // Quad IO fast read
	localparam logic [DATA_W-1:0] FLASH_MODE = 8'hA5;
	localparam int FLASH_DUMMY_CLKS = 4;

	// Reader step numbers, counted in SCLK half-cycles after chip select drops
	localparam int FLASH_HDR_CLKS = 8; // Command, address and mode
	localparam int FLASH_OE_OFF_STEP = 2 * FLASH_HDR_CLKS;
	localparam int FLASH_HI_STEP = 2 * (FLASH_HDR_CLKS + FLASH_DUMMY_CLKS) + 1;
	localparam int FLASH_LO_STEP = FLASH_HI_STEP + 2;

	typedef enum logic [3:0] {
		IDL_LDN, INC, DEC, SBRANCH,
		LDA, STR, IO, MISC7,
		GLO, GHI, PLO, PHI,
		LBR_SKIP, SEP, SEX, MISCF
	} op_group_t;

	typedef enum logic [3:0] {
		OR, AND, XOR,
		ADD, ADC,
		SD, SDB, SM, SMB,
		SHR, SHL, RSHR, RSHL,
		PASS
	} alu_op_t;

	typedef enum logic [2:0] {
		FETCH,
		WAIT_FETCH,
		EXECUTE,
		WAIT_OPERAND,
		WAIT_LOAD,
		WAIT_STORE,
		HALTED
	} seq_state_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic write;
	} mem_req_t;

endpackage

`default_nettype wire

/* cpu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer import cpu_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [3:0] ef_n,
	output mem_req_t mem_req,
	output logic mem_start,
	input wire logic mem_done,
	input wire logic [DATA_W-1:0] mem_rdata,
	output alu_op_t alu_op,
	output logic [DATA_W-1:0] alu_d,
	output logic alu_df,
	output logic [DATA_W-1:0] alu_b,
	input wire logic [DATA_W-1:0] alu_d_next,
	input wire logic alu_df_next,
	output logic q
);

	logic [ADDR_W-1:0] regs [NREGS];
	logic [REG_AW-1:0] p, x;
	logic [DATA_W-1:0] d, b, ir;
	logic df;
	logic [3:0] ef;
	logic operand_ok; // B holds the operand of the current instruction
	seq_state_t state;

	op_group_t grp;
	logic [3:0] n;
	logic cond, take;
	logic ex_load, ex_store, ex_halt, ex_inc, ex_dec;
	logic need_b, use_alu, ex_issue;
	logic [REG_AW-1:0] ex_areg;
	alu_op_t alu_sel;

	assign grp = op_group_t'(ir[7:4]);
	assign n = ir[3:0];

	always_comb begin
		case (n[2:0])
			3'd0: cond = 1'b1;
			3'd1: cond = q;
			3'd2: cond = (d == '0);
			3'd3: cond = df;
			default: cond = ef[n[1:0]];
		endcase
		take = cond ^ n[3]; // Upper half of the group inverts
	end

	always_comb begin
		ex_load = 1'b0;
		ex_store = 1'b0;
		ex_halt = 1'b0;
		ex_inc = 1'b0;
		ex_dec = 1'b0;
		need_b = 1'b0;
		ex_areg = n;
		alu_sel = PASS;
		case (grp)
			IDL_LDN: begin
				ex_halt = (n == 4'h0);
				ex_load = (n != 4'h0);
			end
			SBRANCH: begin
				need_b = take;
				ex_areg = p;
			end
			LDA: begin
				ex_load = 1'b1;
				ex_inc = 1'b1;
			end
			STR: ex_store = 1'b1;
			MISC7: begin
				ex_areg = n[3] ? p : x;
				ex_inc = n[3] || (n == 4'h2);
				case (n)
					4'h2: ex_load = 1'b1; // LDXA
					4'h3: begin // STXD
						ex_store = 1'b1;
						ex_dec = 1'b1;
					end
					4'h4, 4'hC: alu_sel = ADC;
					4'h5, 4'hD: alu_sel = SDB;
					4'h7, 4'hF: alu_sel = SMB;
					4'h6: alu_sel = RSHR;
					4'hE: alu_sel = RSHL;
					default: ;
				endcase
				need_b = (alu_sel inside {ADC, SDB, SMB});
			end
			MISCF: begin
				ex_areg = n[3] ? p : x;
				ex_inc = n[3];
				case (n[2:0])
					3'd0: ex_load = 1'b1; // LDX, LDI
					3'd1: alu_sel = OR;
					3'd2: alu_sel = AND;
					3'd3: alu_sel = XOR;
					3'd4: alu_sel = ADD;
					3'd5: alu_sel = SD;
					3'd6: alu_sel = n[3] ? SHL : SHR;
					default: alu_sel = SM;
				endcase
				need_b = (n[2:0] != 3'd0) && (n[2:0] != 3'd6);
			end
			default: ;
		endcase
		use_alu = (alu_sel != PASS);
		ex_issue = ex_load || ex_store || (need_b && !operand_ok);
	end

	always_comb begin
		mem_req = '{addr: regs[ex_areg], wdata: d, write: ex_store};
		mem_start = 1'b0;
		if (state == FETCH) begin
			mem_req.addr = regs[p];
			mem_req.write = 1'b0;
			mem_start = 1'b1;
		end else if (state == EXECUTE) begin
			mem_start = ex_issue;
		end
	end

	assign alu_op = alu_sel;
	assign alu_d = d;
	assign alu_df = df;
	assign alu_b = b;

	always_ff @(posedge clk) begin
		ef <= ~ef_n;
		if (!rst_n) begin
			state <= FETCH;
			regs[0] <= '0;
			p <= '0;
			x <= '0;
			d <= '0;
			df <= 1'b0;
			q <= 1'b0;
			operand_ok <= 1'b0;
		end else begin
			case (state)
				FETCH: begin
					regs[p] <= regs[p] + 1'b1;
					state <= WAIT_FETCH;
				end
				WAIT_FETCH: if (mem_done) begin
					ir <= mem_rdata;
					state <= EXECUTE;
				end
				EXECUTE: if (ex_halt) begin
					state <= HALTED;
				end else if (ex_issue) begin
					if (ex_inc)
						regs[ex_areg] <= regs[ex_areg] + 1'b1;
					else if (ex_dec)
						regs[ex_areg] <= regs[ex_areg] - 1'b1;
					state <= ex_load ? WAIT_LOAD : (ex_store ? WAIT_STORE : WAIT_OPERAND);
				end else begin
					operand_ok <= 1'b0;
					state <= FETCH;
					if (use_alu) begin
						d <= alu_d_next;
						df <= alu_df_next;
					end
					case (grp)
						INC: regs[n] <= regs[n] + 1'b1;
						DEC: regs[n] <= regs[n] - 1'b1;
						SBRANCH: begin
							if (operand_ok)
								regs[p][7:0] <= b; // Target within the page
							else
								regs[p] <= regs[p] + 1'b1;
						end
						GLO: d <= regs[n][7:0];
						GHI: d <= regs[n][15:8];
						PLO: regs[n][7:0] <= d;
						PHI: regs[n][15:8] <= d;
						SEP: p <= n;
						SEX: x <= n;
						MISC7: begin
							if (n == 4'hA)
								q <= 1'b0;
							else if (n == 4'hB)
								q <= 1'b1;
						end
						default: ; // NOP and dropped opcodes
					endcase
				end
				WAIT_OPERAND: if (mem_done) begin
					b <= mem_rdata;
					operand_ok <= 1'b1;
					state <= EXECUTE;
				end
				WAIT_LOAD: if (mem_done) begin
					d <= mem_rdata;
					state <= FETCH;
				end
				WAIT_STORE: if (mem_done)
					state <= FETCH;
				default: ; // HALTED until reset
			endcase
		end
	end

	// One access in flight, a done only answers an outstanding request
	a_done_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
		mem_done |-> (state inside {WAIT_FETCH, WAIT_OPERAND, WAIT_LOAD, WAIT_STORE}));

endmodule

`default_nettype wire

/* flist.f */
cpu_pkg.sv
alu_8bit.sv
qspi_rom_reader.sv
mem_router.sv
cpu_sequencer.sv
cdp1802_top.sv
tb_clock_gen.sv
tb_flash_model.sv
tb_top.sv

/* mem_router.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_router import cpu_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire mem_req_t mem_req,
	input wire logic mem_start,
	output logic mem_done,
	output logic [DATA_W-1:0] mem_rdata,
	input wire logic [3:0] rom_din,
	output logic [3:0] rom_dout,
	output logic [3:0] rom_oe,
	output logic rom_cs_n,
	output logic rom_sclk
);

	logic [DATA_W-1:0] ram [RAM_DEPTH];
	logic [DATA_W-1:0] ram_q;
	logic [RAM_AW-1:0] ram_idx;
	logic is_ram;
	logic local_done;
	logic rd_start;
	logic rd_done;
	logic [DATA_W-1:0] rd_data;

	assign is_ram = mem_req.addr[RAM_BASE_BIT];
	assign ram_idx = mem_req.addr[RAM_AW-1:0];
	assign rd_start = mem_start && !is_ram && !mem_req.write;

	always_ff @(posedge clk) begin
		if (!rst_n)
			local_done <= 1'b0;
		else
			local_done <= mem_start && (is_ram || mem_req.write); // Flash writes just finish
	end

	always_ff @(posedge clk) begin
		if (mem_start && is_ram) begin
			if (mem_req.write)
				ram[ram_idx] <= mem_req.wdata;
			ram_q <= ram[ram_idx];
		end
	end

	assign mem_done = local_done || rd_done;
	assign mem_rdata = rd_done ? rd_data : ram_q;

	qspi_rom_reader u_rom (
		.clk(clk),
		.rst_n(rst_n),
		.rd_start(rd_start),
		.rd_addr(mem_req.addr),
		.rd_done(rd_done),
		.rd_data(rd_data),
		.rom_din(rom_din),
		.rom_dout(rom_dout),
		.rom_oe(rom_oe),
		.rom_cs_n(rom_cs_n),
		.rom_sclk(rom_sclk)
	);

endmodule

`default_nettype wire

/* qspi_rom_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module qspi_rom_reader import cpu_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic rd_start,
	input wire logic [ADDR_W-1:0] rd_addr,
	output logic rd_done,
	output logic [DATA_W-1:0] rd_data,
	input wire logic [3:0] rom_din,
	output logic [3:0] rom_dout,
	output logic [3:0] rom_oe,
	output logic rom_cs_n,
	output logic rom_sclk
);

	logic busy;
	logic [4:0] step;
	logic [ADDR_W-1:0] last_addr;
	logic [ADDR_W+11:0] shreg; // Nibbles still to send after the first
	logic [3:0] hi_nib;
	logic cont;

	// Flash still selected and streaming the next byte
	assign cont = !rom_cs_n && (rd_addr == last_addr + 1'b1);

	always_ff @(posedge clk) begin
		rd_done <= 1'b0;
		if (!rst_n) begin
			busy <= 1'b0;
			step <= '0;
			last_addr <= '0;
			rom_cs_n <= 1'b1;
			rom_sclk <= 1'b0;
			rom_oe <= 4'h0;
			rom_dout <= 4'h0;
		end else if (!busy) begin
			if (rd_start) begin
				busy <= 1'b1;
				last_addr <= rd_addr;
				if (cont) begin
					step <= 5'(FLASH_HI_STEP - 1); // Data clocks only
				end else begin
					rom_cs_n <= 1'b1;
					rom_sclk <= 1'b0;
					rom_dout <= FLASH_CMD_READ[7:4];
					rom_oe <= 4'hF;
					shreg <= {FLASH_CMD_READ[3:0], rd_addr, FLASH_MODE};
					step <= '0;
				end
			end
		end else if (step == '0) begin
			rom_cs_n <= 1'b0;
			step <= 5'd1;
		end else begin
			step <= step + 1'b1;
			if (step[0]) begin
				rom_sclk <= 1'b1;
				if (step == 5'(FLASH_HI_STEP))
					hi_nib <= rom_din;
				if (step == 5'(FLASH_LO_STEP)) begin
					rd_data <= {hi_nib, rom_din};
					rd_done <= 1'b1;
					busy <= 1'b0; // SCLK parks high for a follow-on read
				end
			end else begin
				rom_sclk <= 1'b0;
				if (step < 5'(FLASH_OE_OFF_STEP)) begin
					rom_dout <= shreg[ADDR_W+11:ADDR_W+8];
					shreg <= {shreg[ADDR_W+7:0], 4'h0};
				end else begin
					rom_oe <= 4'h0; // Dummy clocks, flash takes the bus
					rom_dout <= 4'h0;
				end
			end
		end
	end

	// Router must wait for the previous done before starting again
	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		rd_start |-> !busy);

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	input wire logic reset_req,
	output logic clk,
	output logic rst_n
);

	logic [4:0] cnt;

	initial begin
		clk = 1'b0;
		cnt = 5'd15;
		rst_n = 1'b1;
		#1 rst_n = 1'b0; // Edge that clears the flash model log
	end

	always #10 clk = ~clk;

	// Reset stays low for 16 rising edges after a request
	always @(posedge clk) begin
		if (reset_req) begin
			rst_n <= 1'b0;
			cnt <= 5'd15;
		end else if (cnt != 5'd0)
			cnt <= cnt - 1'b1;
		else
			rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* tb_flash_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_flash_model (
	input wire logic rst_n,
	input wire logic rom_cs_n,
	input wire logic rom_sclk,
	input wire logic [3:0] rom_dout,
	input wire logic [3:0] rom_oe,
	output logic [3:0] rom_din,
	input wire logic [127:0] image, // Byte 0 in the top bits
	output int fetch_count,
	output logic [15:0] first_fetch,
	output logic [15:0] last_fetch,
	output logic [7:0] first_cmd
);

	int rises; // SCLK rises since chip select dropped
	logic [7:0] cmd;
	logic [15:0] addr;
	logic [16:0] ptr; // Nibble pointer, low bit picks the low nibble
	logic [7:0] cur;
	logic sclk_q;

	function automatic logic [7:0] byte_at(input logic [15:0] a);
		if (a < 16'd16)
			return image[8*(15-a) +: 8];
		return a[15:8] ^ a[7:0] ^ 8'hC4; // Outside the program
	endfunction

	always @(posedge rom_sclk or negedge rom_sclk or negedge rom_cs_n or negedge rst_n) begin
		if (!rst_n) begin
			fetch_count = 0;
			first_cmd = 8'h00;
			first_fetch = 16'hFFFF;
			last_fetch = 16'hFFFF;
			rises = 0;
			sclk_q = rom_sclk;
			rom_din <= 4'h0;
		end else if (rom_sclk && !sclk_q) begin
			sclk_q = 1'b1;
			if (!rom_cs_n) begin
				if (rises < 2 && rom_oe == 4'hF)
					cmd = {cmd[3:0], rom_dout};
				else if (rises < 6)
					addr = {addr[11:0], rom_dout};
				rises++;
				if (rises == 2 && fetch_count == 0)
					first_cmd = cmd;
				if (rises == 6)
					ptr = {addr, 1'b0};
				// High nibble of a byte just taken by the reader
				if (rises > 12 && ptr[0]) begin
					if (fetch_count == 0)
						first_fetch = ptr[16:1];
					last_fetch = ptr[16:1];
					fetch_count++;
				end
			end
		end else if (!rom_sclk && sclk_q) begin
			sclk_q = 1'b0;
			if (!rom_cs_n && rises >= 12) begin
				cur = byte_at(ptr[16:1]);
				rom_din <= ptr[0] ? cur[3:0] : cur[7:4];
				ptr = ptr + 1'b1;
			end
		end else if (!rom_cs_n) begin
			rises = 0; // New command
		end
	end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	typedef struct packed {
		logic [127:0] prog;
		logic [3:0] ef_n;
		logic q;
		logic [15:0] last;
	} tcase_t;

	logic clk, rst_n, reset_req;
	logic [3:0] ef_n, rom_din, rom_dout, rom_oe;
	logic rom_cs_n, rom_sclk, q;
	logic [127:0] image;
	int fetch_count;
	logic [15:0] first_fetch, last_fetch;
	logic [7:0] first_cmd;
	tcase_t tbl[$];

	tb_clock_gen u_clk (.reset_req(reset_req), .clk(clk), .rst_n(rst_n));

	tb_flash_model u_flash (
		.rst_n(rst_n), .rom_cs_n(rom_cs_n), .rom_sclk(rom_sclk),
		.rom_dout(rom_dout), .rom_oe(rom_oe), .rom_din(rom_din), .image(image),
		.fetch_count(fetch_count), .first_fetch(first_fetch),
		.last_fetch(last_fetch), .first_cmd(first_cmd)
	);

	cdp1802_top dut0 (
		.clk(clk), .rst_n(rst_n), .ef_n(ef_n), .rom_din(rom_din),
		.rom_dout(rom_dout), .rom_oe(rom_oe), .rom_cs_n(rom_cs_n),
		.rom_sclk(rom_sclk), .q(q)
	);

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_stop($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	function automatic void add_case(input logic [127:0] prog, input logic [3:0] en,
		input logic eq, input logic [15:0] last);
		tbl.push_back('{prog: prog, ef_n: en, q: eq, last: last});
	endfunction

	task automatic run_case(input int i);
		int waited;
		int idle;
		int prev;
		@(posedge clk);
		image <= tbl[i].prog;
		ef_n <= tbl[i].ef_n;
		reset_req <= 1'b1;
		@(posedge clk);
		reset_req <= 1'b0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > 100)
				fail_stop($sformatf("case %0d: reset never released", i));
		end while (!rst_n);
		check($sformatf("case %0d rom_cs_n after reset", i), rom_cs_n, 1'b1);
		check($sformatf("case %0d rom_sclk after reset", i), rom_sclk, 1'b0);
		check($sformatf("case %0d q after reset", i), q, 1'b0);
		// Run until the fetch log stays quiet
		waited = 0;
		idle = 0;
		prev = fetch_count;
		while (idle < 200) begin
			@(negedge clk);
			waited++;
			if (fetch_count != prev) begin
				prev = fetch_count;
				idle = 0;
			end else
				idle++;
			if (waited > 20000)
				fail_stop($sformatf("case %0d: program kept fetching, no halt seen", i));
		end
		check($sformatf("case %0d first fetch", i), first_fetch, 16'h0000);
		check($sformatf("case %0d first command", i), first_cmd, 8'hEB);
		check($sformatf("case %0d last fetch", i), last_fetch, tbl[i].last);
		check($sformatf("case %0d q", i), q, tbl[i].q);
		check($sformatf("case %0d rom_oe after halt", i), rom_oe, 4'h0); // Flash owns the data lines
	endtask

	initial begin
		reset_req = 1'b0;
		ef_n = 4'hF;
		image = '0;
		// ALU immediates, then BDF or BZ over SEQ
		add_case(128'hF890FC80_33087B00_00000000_00000000, 4'hF, 1'b0, 16'h0008);
		add_case(128'hF810FC20_33087B00_00000000_00000000, 4'hF, 1'b1, 16'h0007);
		add_case(128'hF810FD30_33087B00_00000000_00000000, 4'hF, 1'b0, 16'h0008);
		add_case(128'hF844FF44_32087B00_00000000_00000000, 4'hF, 1'b0, 16'h0008);
		add_case(128'hF810FF20_33087B00_00000000_00000000, 4'hF, 1'b1, 16'h0007);
		add_case(128'hF80FF930_32087B00_00000000_00000000, 4'hF, 1'b1, 16'h0007);
		add_case(128'hF8F0FA0F_32087B00_00000000_00000000, 4'hF, 1'b0, 16'h0008);
		add_case(128'hF85AFB5A_32087B00_00000000_00000000, 4'hF, 1'b0, 16'h0008);
		add_case(128'hF85AFB0F_32087B00_00000000_00000000, 4'hF, 1'b1, 16'h0007);
		add_case(128'hF881F633_077B0000_00000000_00000000, 4'hF, 1'b0, 16'h0007); // SHR
		add_case(128'hF840FE33_077B0000_00000000_00000000, 4'hF, 1'b1, 16'h0006); // SHL
		// Q, D zero and unconditional branches
		add_case(128'h7B31057A_00000000_00000000_00000000, 4'hF, 1'b1, 16'h0005);
		add_case(128'h7B39057A_00000000_00000000_00000000, 4'hF, 1'b0, 16'h0004);
		add_case(128'hF8003A06_7B000000_00000000_00000000, 4'hF, 1'b1, 16'h0005);
		add_case(128'h30047B00_00000000_00000000_00000000, 4'hF, 1'b0, 16'h0004);
		// EF flags, active low on the pins
		add_case(128'h34047B00_00000000_00000000_00000000, 4'hE, 1'b0, 16'h0004);
		add_case(128'h35047B00_00000000_00000000_00000000, 4'hF, 1'b1, 16'h0003);
		add_case(128'h36047B00_00000000_00000000_00000000, 4'hB, 1'b0, 16'h0004);
		add_case(128'h37047B00_00000000_00000000_00000000, 4'hE, 1'b1, 16'h0003);
		add_case(128'h3C047B00_00000000_00000000_00000000, 4'hF, 1'b0, 16'h0004);
		add_case(128'h3D047B00_00000000_00000000_00000000, 4'hD, 1'b1, 16'h0003);
		add_case(128'h3E047B00_00000000_00000000_00000000, 4'h0, 1'b1, 16'h0003);
		add_case(128'h3F047B00_00000000_00000000_00000000, 4'hE, 1'b0, 16'h0004);
		// RAM round trip through R1 = 8080h
		add_case(128'hF880B1A1_F83C51F6_01FB3C3A_0F7B0000, 4'hF, 1'b1, 16'h000E);
		for (int i = 0; i < tbl.size(); i++)
			run_case(i);
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire
